// File: run.sh
#!/bin/sh
# Build the CPU testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module cpu_tb -f src.f -o cpu_tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/cpu_tb_sim 2>&1)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST PASSED"; then
    exit 0
else
    echo "Pass message not found in simulation output"
    exit 1
fi

// File: src.f
verilog/cpu_pkg.sv
verilog/program_counter.sv
verilog/program_rom.sv
verilog/instruction_decoder.sv
verilog/register_file.sv
verilog/alu.sv
verilog/cpu.sv
test/cpu_tb.sv

// File: test/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;

    localparam int n = 8;

    // About 30 instructions are executed, with margin for the limit
    localparam int test_cycles = 40;
    localparam int max_cycles  = 5 * test_cycles;

    logic                             clk;
    logic                             reset;
    logic [cpu_pkg::switch_width-1:0] sw;
    logic [n-1:0]                     leds;
    cpu_pkg::pc_t                     pc;

    int    cycle_count = 0;
    string test_name   = "init";

    cpu #(.n(n)) cpu_i (
        .clk   (clk),
        .reset (reset),
        .sw    (sw),
        .leds  (leds),
        .pc    (pc)
    );

    initial
    begin
        clk = 1'b0;
    end

    always #4 clk = ~clk;

    // Print the reason and stop the run
    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles)
        begin
            stop_with_failure($sformatf("Timeout: run did not finish within %0d cycles",
                                        max_cycles));
        end
    end

    task automatic check_leds(input string what, input logic [n-1:0] expected);
        if (leds !== expected)
        begin
            stop_with_failure($sformatf("FAILED %s %s: expected leds %0d, actual %0d",
                                        test_name, what, expected, leds));
        end
    endtask

    task automatic check_pc(input string what, input cpu_pkg::pc_t expected);
        if (pc !== expected)
        begin
            stop_with_failure($sformatf("FAILED %s %s: expected pc %0d, actual %0d",
                                        test_name, what, expected, pc));
        end
    endtask

    // One instruction commits, returns on the falling edge
    task automatic next_cycle();
        @(posedge clk);
        @(negedge clk);
    endtask

    // Let combinational outputs settle after a drive
    task automatic settle();
        #1;
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic run_reset_test();
        test_name = "reset";
        apply_reset();
        settle();
        check_pc("after first reset", 5'd0);
        check_leds("after first reset", 8'd60);
        for (int step = 1; step < 3; step++)
        begin
            next_cycle();
            settle();
            check_pc($sformatf("step %0d", step), cpu_pkg::pc_t'(step));
        end
        // Third instruction commits, then reset again
        next_cycle();
        apply_reset();
        settle();
        check_pc("after second reset", 5'd0);
        check_leds("after second reset", 8'd60);
    endtask

    task automatic run_arithmetic_test();
        logic [n-1:0] expected_leds [5];
        test_name     = "arithmetic";
        expected_leds = '{8'd60, 8'd54, 8'd114, 8'd0, 8'd65};
        for (int i = 0; i < 5; i++)
        begin
            settle();
            check_pc($sformatf("address %0d", i), cpu_pkg::pc_t'(i));
            check_leds($sformatf("address %0d", i), expected_leds[i]);
            next_cycle();
        end
    endtask

    task automatic run_switch_test();
        test_name = "switches";
        sw = {1'b0, 8'd30};
        settle();
        check_pc("swr r5", 5'd5);
        check_leds("swr r5", 8'd30);
        next_cycle();
        sw = {1'b0, 8'd253};
        settle();
        check_pc("swr r6", 5'd6);
        check_leds("swr r6", 8'd253);
        next_cycle();
        sw = {1'b1, 8'd253};
        settle();
        check_pc("swb r7", 5'd7);
        check_leds("swb r7", 8'hff);
        next_cycle();
        settle();
        // Low byte of 253 times 30
        check_pc("mul", 5'd8);
        check_leds("mul", 8'd166);
        next_cycle();
    endtask

    task automatic run_branch_test();
        cpu_pkg::pc_t expected_pc   [6];
        logic [n-1:0] expected_leds [6];
        test_name     = "branches";
        expected_pc   = '{5'd9, 5'd10, 5'd11, 5'd12, 5'd16, 5'd17};
        // Branches show rs minus rd: r9 - r8 = 0, r3 - r8 = 60
        expected_leds = '{8'd5, 8'd5, 8'd0, 8'd0, 8'd60, 8'd60};
        sw = '0;
        for (int i = 0; i < 6; i++)
        begin
            settle();
            check_pc($sformatf("step %0d", i), expected_pc[i]);
            check_leds($sformatf("address %0d", expected_pc[i]), expected_leds[i]);
            next_cycle();
        end
    endtask

    task automatic run_switch_wait_test();
        test_name = "switch wait";
        for (int i = 0; i < 2; i++)
        begin
            settle();
            check_pc($sformatf("bsc hold %0d", i), 5'd21);
            check_leds("bsc", 8'd0);
            next_cycle();
        end
        sw = 9'h100;
        settle();
        check_pc("bsc hold 2", 5'd21);
        next_cycle();
        settle();
        check_pc("bsc release", 5'd22);
        next_cycle();
        settle();
        check_pc("bss hold 0", 5'd22);
        next_cycle();
        sw = '0;
        settle();
        check_pc("bss hold 1", 5'd22);
        next_cycle();
        settle();
        check_pc("bss release", 5'd23);
    endtask

    initial
    begin
        reset = 1'b1;
        sw    = '0;
        run_reset_test();
        run_arithmetic_test();
        run_switch_test();
        run_branch_test();
        run_switch_wait_test();
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ps

module alu #(
    parameter int n = 8
) (
    input  cpu_pkg::alu_op_t alu_op,
    input  logic [n-1:0]     rs_data,
    input  logic [n-1:0]     rt_data,
    input  logic [n-1:0]     imm,
    input  logic             use_imm,
    input  logic [n-1:0]     switches,
    input  logic             switch_bit,
    output logic [n-1:0]     result,
    output logic             zero
);

    logic [n-1:0] operand_b;

    // Second operand from the immediate or from rt
    assign operand_b = use_imm ? imm : rt_data;

    always_comb
    begin
        case (alu_op)
            cpu_pkg::alu_add:
            begin
                result = rs_data + operand_b;
            end
            cpu_pkg::alu_sub:
            begin
                result = rs_data - operand_b;
            end
            cpu_pkg::alu_mul:
            begin
                // Low half of the product only
                result = rs_data * operand_b;
            end
            cpu_pkg::alu_switches:
            begin
                result = switches;
            end
            cpu_pkg::alu_switch_bit:
            begin
                result = {n{switch_bit}};
            end
            default:
            begin
                result = '0;
            end
        endcase
    end

    // Drives the BEQ and BNE decision
    assign zero = (result == '0);

endmodule

// File: verilog/cpu.sv
`timescale 1ns/1ps

module cpu #(
    parameter int n = 8
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [cpu_pkg::switch_width-1:0]  sw,
    output logic [n-1:0]                      leds,
    output cpu_pkg::pc_t                      pc
);

    cpu_pkg::instr_t    instr;
    cpu_pkg::reg_addr_t rs_addr;
    cpu_pkg::reg_addr_t rt_addr;
    cpu_pkg::reg_addr_t rd_addr;
    cpu_pkg::alu_op_t   alu_op;
    logic [n-1:0]       imm;
    logic [n-1:0]       rs_data;
    logic [n-1:0]       rt_data;
    logic [n-1:0]       result;
    logic [n-1:0]       sw_low;
    logic               use_imm;
    logic               reg_write;
    logic               zero;
    logic               branch_taken;

    // Low eight switches sized to the data width
    assign sw_low = n'(sw[7:0]);

    // ALU result is always visible on the board
    assign leds = result;

    program_counter #(.n(n)) pc_i (
        .clk          (clk),
        .reset        (reset),
        .branch_taken (branch_taken),
        .imm          (imm),
        .pc           (pc)
    );

    program_rom #(.n(n)) rom_i (
        .pc    (pc),
        .instr (instr)
    );

    instruction_decoder #(.n(n)) decoder_i (
        .instr        (instr),
        .zero         (zero),
        .switch_bit   (sw[cpu_pkg::switch_width-1]),
        .rs_addr      (rs_addr),
        .rt_addr      (rt_addr),
        .rd_addr      (rd_addr),
        .imm          (imm),
        .use_imm      (use_imm),
        .alu_op       (alu_op),
        .reg_write    (reg_write),
        .branch_taken (branch_taken)
    );

    register_file #(.n(n)) regs_i (
        .clk       (clk),
        .reset     (reset),
        .rs_addr   (rs_addr),
        .rt_addr   (rt_addr),
        .rd_addr   (rd_addr),
        .reg_write (reg_write),
        .wr_data   (result),
        .rs_data   (rs_data),
        .rt_data   (rt_data)
    );

    alu #(.n(n)) alu_i (
        .alu_op     (alu_op),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .imm        (imm),
        .use_imm    (use_imm),
        .switches   (sw_low),
        .switch_bit (sw[cpu_pkg::switch_width-1]),
        .result     (result),
        .zero       (zero)
    );

endmodule

// File: verilog/cpu_pkg.sv
package cpu_pkg;

    // Word and address widths
    localparam int instr_width    = 24;
    localparam int reg_addr_width = 5;
    localparam int pc_width       = 5;
    localparam int switch_width   = 9;

    typedef logic [pc_width-1:0]       pc_t;
    typedef logic [reg_addr_width-1:0] reg_addr_t;

    // Instruction opcodes
    typedef enum logic [3:0] {
        op_nop  = 4'd0,
        op_addi = 4'd1,
        op_add  = 4'd2,
        op_sub  = 4'd3,
        op_mul  = 4'd4,
        op_swr  = 4'd5,
        op_swb  = 4'd6,
        op_beq  = 4'd7,
        op_bne  = 4'd8,
        op_bsc  = 4'd9,
        op_bss  = 4'd10
    } opcode_t;

    // Operations the ALU can perform
    typedef enum logic [2:0] {
        alu_zero       = 3'd0,
        alu_add        = 3'd1,
        alu_sub        = 3'd2,
        alu_mul        = 3'd3,
        alu_switches   = 3'd4,
        alu_switch_bit = 3'd5
    } alu_op_t;

    // Register format: three register addresses
    typedef struct packed {
        opcode_t   opcode;
        reg_addr_t rd;
        reg_addr_t rs;
        reg_addr_t rt;
        logic [instr_width-4-3*reg_addr_width-1:0] unused;
    } reg_format_t;

    // Immediate format, also used by branches for the offset
    typedef struct packed {
        opcode_t    opcode;
        reg_addr_t  rd;
        reg_addr_t  rs;
        logic [7:0] imm;
        logic [instr_width-4-2*reg_addr_width-8-1:0] unused;
    } imm_format_t;

    typedef union packed {
        reg_format_t r;
        imm_format_t i;
    } instr_t;

endpackage

// File: verilog/instruction_decoder.sv
`timescale 1ns/1ps

module instruction_decoder #(
    parameter int n = 8
) (
    input  cpu_pkg::instr_t    instr,
    input  logic               zero,
    input  logic               switch_bit,
    output cpu_pkg::reg_addr_t rs_addr,
    output cpu_pkg::reg_addr_t rt_addr,
    output cpu_pkg::reg_addr_t rd_addr,
    output logic [n-1:0]       imm,
    output logic               use_imm,
    output cpu_pkg::alu_op_t   alu_op,
    output logic               reg_write,
    output logic               branch_taken
);

    cpu_pkg::opcode_t opcode;

    assign opcode  = instr.r.opcode;
    assign rd_addr = instr.r.rd;
    assign rs_addr = instr.r.rs;

    // Immediate view, sign extended to the data width
    assign imm = n'($signed(instr.i.imm));

    always_comb
    begin
        rt_addr   = instr.r.rt;
        use_imm   = 1'b0;
        alu_op    = cpu_pkg::alu_zero;
        reg_write = 1'b0;
        case (opcode)
            cpu_pkg::op_addi:
            begin
                use_imm   = 1'b1;
                alu_op    = cpu_pkg::alu_add;
                reg_write = 1'b1;
            end
            cpu_pkg::op_add:
            begin
                alu_op    = cpu_pkg::alu_add;
                reg_write = 1'b1;
            end
            cpu_pkg::op_sub:
            begin
                alu_op    = cpu_pkg::alu_sub;
                reg_write = 1'b1;
            end
            cpu_pkg::op_mul:
            begin
                alu_op    = cpu_pkg::alu_mul;
                reg_write = 1'b1;
            end
            cpu_pkg::op_swr:
            begin
                alu_op    = cpu_pkg::alu_switches;
                reg_write = 1'b1;
            end
            cpu_pkg::op_swb:
            begin
                alu_op    = cpu_pkg::alu_switch_bit;
                reg_write = 1'b1;
            end
            cpu_pkg::op_beq, cpu_pkg::op_bne:
            begin
                // Compare rs against rd through the second read port
                rt_addr = instr.i.rd;
                alu_op  = cpu_pkg::alu_sub;
            end
            default:
            begin
                // Nop and wait branches, result zero and no write
            end
        endcase
    end

    // Branch decision from the zero flag and switch 8
    always_comb
    begin
        case (opcode)
            cpu_pkg::op_beq: branch_taken = zero;
            cpu_pkg::op_bne: branch_taken = !zero;
            cpu_pkg::op_bsc: branch_taken = !switch_bit;
            cpu_pkg::op_bss: branch_taken = switch_bit;
            default:         branch_taken = 1'b0;
        endcase
    end

endmodule

// File: verilog/program_counter.sv
`timescale 1ns/1ps

module program_counter #(
    parameter int n = 8
) (
    input  logic         clk,
    input  logic         reset,
    input  logic         branch_taken,
    input  logic [n-1:0] imm,
    output cpu_pkg::pc_t pc
);

    cpu_pkg::pc_t offset;
    cpu_pkg::pc_t pc_next;

    // Signed branch offset, taken modulo the ROM size
    assign offset = cpu_pkg::pc_t'($signed(imm));

    always_comb
    begin
        if (branch_taken)
        begin
            pc_next = pc + offset;
        end
        else
        begin
            // Wraps from 31 back to 0
            pc_next = pc + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pc <= '0;
        end
        else
        begin
            pc <= pc_next;
        end
    end

endmodule

// File: verilog/program_rom.sv
`timescale 1ns/1ps

module program_rom #(
    parameter int n = 8
) (
    input  cpu_pkg::pc_t    pc,
    output cpu_pkg::instr_t instr
);

    // Build a register format word
    function automatic cpu_pkg::instr_t r_type(cpu_pkg::opcode_t op,
                                               cpu_pkg::reg_addr_t rd,
                                               cpu_pkg::reg_addr_t rs,
                                               cpu_pkg::reg_addr_t rt);
        cpu_pkg::instr_t word;
        word          = '0;
        word.r.opcode = op;
        word.r.rd     = rd;
        word.r.rs     = rs;
        word.r.rt     = rt;
        return word;
    endfunction

    // Build an immediate format word, value given at data width
    function automatic cpu_pkg::instr_t i_type(cpu_pkg::opcode_t op,
                                               cpu_pkg::reg_addr_t rd,
                                               cpu_pkg::reg_addr_t rs,
                                               logic [n-1:0] value);
        cpu_pkg::instr_t word;
        word          = '0;
        word.i.opcode = op;
        word.i.rd     = rd;
        word.i.rs     = rs;
        word.i.imm    = 8'(value);
        return word;
    endfunction

    always_comb
    begin
        case (pc)
            5'd0:    instr = i_type(cpu_pkg::op_addi, 5'd3, 5'd0, n'(60));
            5'd1:    instr = i_type(cpu_pkg::op_addi, 5'd4, 5'd0, n'(54));
            5'd2:    instr = r_type(cpu_pkg::op_add, 5'd3, 5'd3, 5'd4);
            5'd4:    instr = i_type(cpu_pkg::op_addi, 5'd3, 5'd0, n'(65));
            5'd5:    instr = r_type(cpu_pkg::op_swr, 5'd5, 5'd0, 5'd0);
            5'd6:    instr = r_type(cpu_pkg::op_swr, 5'd6, 5'd0, 5'd0);
            5'd7:    instr = r_type(cpu_pkg::op_swb, 5'd7, 5'd0, 5'd0);
            5'd8:    instr = r_type(cpu_pkg::op_mul, 5'd6, 5'd6, 5'd5);
            5'd9:    instr = i_type(cpu_pkg::op_addi, 5'd8, 5'd0, n'(5));
            5'd10:   instr = i_type(cpu_pkg::op_addi, 5'd9, 5'd0, n'(5));
            5'd11:   instr = i_type(cpu_pkg::op_bne, 5'd8, 5'd9, n'(3));
            5'd12:   instr = i_type(cpu_pkg::op_beq, 5'd8, 5'd9, n'(4));
            5'd16:   instr = i_type(cpu_pkg::op_beq, 5'd8, 5'd3, n'(3));
            5'd17:   instr = i_type(cpu_pkg::op_bne, 5'd8, 5'd3, n'(4));
            // Wait loops on switch 8
            5'd21:   instr = i_type(cpu_pkg::op_bsc, 5'd0, 5'd0, n'(0));
            5'd22:   instr = i_type(cpu_pkg::op_bss, 5'd0, 5'd0, n'(0));
            default: instr = r_type(cpu_pkg::op_nop, 5'd0, 5'd0, 5'd0);
        endcase
    end

endmodule

// File: verilog/register_file.sv
`timescale 1ns/1ps

module register_file #(
    parameter int n = 8
) (
    input  logic               clk,
    input  logic               reset,
    input  cpu_pkg::reg_addr_t rs_addr,
    input  cpu_pkg::reg_addr_t rt_addr,
    input  cpu_pkg::reg_addr_t rd_addr,
    input  logic               reg_write,
    input  logic [n-1:0]       wr_data,
    output logic [n-1:0]       rs_data,
    output logic [n-1:0]       rt_data
);

    localparam int depth = 2 ** cpu_pkg::reg_addr_width;

    logic [n-1:0] gpr [depth];

    // Two asynchronous read ports
    assign rs_data = gpr[rs_addr];
    assign rt_data = gpr[rt_addr];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            // Whole file clears, r0 included
            for (int i = 0; i < depth; i++)
            begin
                gpr[i] <= '0;
            end
        end
        else if (reg_write)
        begin
            gpr[rd_addr] <= wr_data;
        end
    end

endmodule
